// ==== rtl/axi_rd_pkg.sv ====
/* AXI read subordinate definitions */

package axi_rd_pkg;

    // ------------------------------------------------------------------------
    // Widths and timing
    // ------------------------------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    // Byte offset bits inside one data word
    localparam int BYTE_W = $clog2(DATA_W / 8);
    localparam int ID_W = 4;

    // Cycles from an accepted component request to its read data
    localparam int COMP_LAT = 2;
    // One stage per word in flight plus one for the R stall
    localparam int SKID_STAGES = COMP_LAT + 1;

    // ------------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------------
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ID_W-1:0] id_t;
    // Beats in burst minus one
    typedef logic [7:0] len_t;
    // Log2 of bytes per beat
    typedef logic [2:0] size_t;

    // AXI burst type, value 3 is reserved
    typedef enum logic [1:0] {
        BURST_FIXED = 2'd0,
        BURST_INCR  = 2'd1,
        BURST_WRAP  = 2'd2
    } burst_t;

    // Read response, EXOKAY not supported
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2
    } resp_t;

    // Request issue FSM
    typedef enum logic {
        ISSUE_IDLE = 1'b0,
        ISSUE_BUSY = 1'b1
    } issue_state_t;

endpackage

// ==== rtl/rd_burst_issuer.sv ====
/* Read burst request issuer */

`timescale 1ns/100ps

module rd_burst_issuer (
    input  logic               clk,
    input  logic               rst_n,
    // AR channel
    input  logic               i_arvalid,
    input  axi_rd_pkg::addr_t  i_araddr,
    input  axi_rd_pkg::len_t   i_arlen,
    input  axi_rd_pkg::size_t  i_arsize,
    input  axi_rd_pkg::burst_t i_arburst,
    input  axi_rd_pkg::id_t    i_arid,
    output logic               o_arready,
    // Component request side
    input  logic               i_cmp_hld,
    input  logic               i_buf_ready,
    output logic               o_cmp_dv,
    output axi_rd_pkg::addr_t  o_cmp_addr,
    // Accepted request context toward the latency tracker
    output logic               o_req_fire,
    output axi_rd_pkg::id_t    o_req_id,
    output logic               o_req_last
);
    import axi_rd_pkg::*;

    issue_state_t state;
    // Remaining beats after the current one
    len_t         beat_cnt;
    // Full byte address so narrow beats step correctly
    addr_t        cur_addr;
    len_t         cur_len;
    size_t        cur_size;
    burst_t       cur_burst;
    id_t          cur_id;

    addr_t        beat_bytes;
    addr_t        incr_addr;
    addr_t        wrap_mask;
    addr_t        next_addr;
    logic         ar_fire;
    logic         final_fire;

    // ------------------------------------------------------------------------
    // Handshakes
    // ------------------------------------------------------------------------
    // Next AR may land on the final component request
    assign o_arready  = (state == ISSUE_IDLE) || final_fire;
    assign ar_fire    = i_arvalid && o_arready;

    // Hold back requests unless the last skid stage can absorb the data
    assign o_cmp_dv   = (state == ISSUE_BUSY) && i_buf_ready;
    assign o_req_fire = o_cmp_dv && !i_cmp_hld;
    assign o_req_last = (beat_cnt == '0);
    assign o_req_id   = cur_id;
    assign final_fire = o_req_fire && o_req_last;

    // Word aligned request address
    assign o_cmp_addr = {cur_addr[ADDR_W-1:BYTE_W], {BYTE_W{1'b0}}};

    // ------------------------------------------------------------------------
    // Next burst address
    // ------------------------------------------------------------------------
    assign beat_bytes = addr_t'(1) << cur_size;
    // INCR aligns an unaligned start address on the second beat
    assign incr_addr  = (cur_addr & ~(beat_bytes - addr_t'(1))) + beat_bytes;
    // Wrap boundary is beat size times beat count, always a power of two
    assign wrap_mask  = ((addr_t'(cur_len) + addr_t'(1)) << cur_size) - addr_t'(1);

    always_comb begin
        case (cur_burst)
            BURST_FIXED: next_addr = cur_addr;
            BURST_WRAP:  next_addr = (cur_addr & ~wrap_mask) | (incr_addr & wrap_mask);
            default:     next_addr = incr_addr;
        endcase
    end

    // ------------------------------------------------------------------------
    // FSM and beat counter
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ISSUE_IDLE;
            beat_cnt <= '0;
        end else if (ar_fire) begin
            state    <= ISSUE_BUSY;
            beat_cnt <= i_arlen;
        end else if (final_fire) begin
            state    <= ISSUE_IDLE;
        end else if (o_req_fire) begin
            beat_cnt <= beat_cnt - 8'd1;
        end
    end

    // Burst context, address steps on every accepted request
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            cur_addr  <= i_araddr;
            cur_len   <= i_arlen;
            cur_size  <= i_arsize;
            cur_burst <= i_arburst;
            cur_id    <= i_arid;
        end else if (o_req_fire) begin
            cur_addr  <= next_addr;
        end
    end

endmodule

// ==== rtl/rd_ctx_tracker.sv ====
/* Request context latency tracker */

`timescale 1ns/100ps

module rd_ctx_tracker (
    input  logic            clk,
    input  logic            rst_n,
    // Accepted component request
    input  logic            i_req_fire,
    input  axi_rd_pkg::id_t i_req_id,
    input  logic            i_req_last,
    // Marks the cycle its read data is on the component bus
    output logic            o_rsp_valid,
    output axi_rd_pkg::id_t o_rsp_id,
    output logic            o_rsp_last
);
    import axi_rd_pkg::*;

    // Entry 0 is one cycle after the request
    logic [COMP_LAT-1:0] valid_sr;
    id_t                 id_sr [COMP_LAT];
    logic [COMP_LAT-1:0] last_sr;

    // ------------------------------------------------------------------------
    // Valid shift register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr[0] <= i_req_fire;
            for (int i = 1; i < COMP_LAT; i++) begin
                valid_sr[i] <= valid_sr[i-1];
            end
        end
    end

    // ------------------------------------------------------------------------
    // Context shift register
    // ------------------------------------------------------------------------
    // Only meaningful where valid_sr is set
    always_ff @(posedge clk) begin
        id_sr[0]   <= i_req_id;
        last_sr[0] <= i_req_last;
        for (int i = 1; i < COMP_LAT; i++) begin
            id_sr[i]   <= id_sr[i-1];
            last_sr[i] <= last_sr[i-1];
        end
    end

    // Oldest entry lines up with the component data
    assign o_rsp_valid = valid_sr[COMP_LAT-1];
    assign o_rsp_id    = id_sr[COMP_LAT-1];
    assign o_rsp_last  = last_sr[COMP_LAT-1];

endmodule

// ==== rtl/rd_skid_stage.sv ====
/* Read data skid stage */

`timescale 1ns/100ps

module rd_skid_stage (
    input  logic              clk,
    input  logic              rst_n,
    // Upstream side
    input  logic              i_valid,
    input  axi_rd_pkg::data_t i_data,
    input  axi_rd_pkg::resp_t i_resp,
    input  axi_rd_pkg::id_t   i_id,
    input  logic              i_last,
    output logic              o_ready,
    // Downstream side
    input  logic              i_ready,
    output logic              o_valid,
    output axi_rd_pkg::data_t o_data,
    output axi_rd_pkg::resp_t o_resp,
    output axi_rd_pkg::id_t   o_id,
    output logic              o_last
);
    import axi_rd_pkg::*;

    // Skid entry
    logic  skid_valid;
    data_t skid_data;
    resp_t skid_resp;
    id_t   skid_id;
    logic  skid_last;

    // ------------------------------------------------------------------------
    // Skid control
    // ------------------------------------------------------------------------
    // Full skid entry blocks upstream
    assign o_ready = !skid_valid;

    // Fill when a word passes in but downstream stalls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            skid_valid <= 1'b0;
        end else if (i_valid && o_ready && !i_ready) begin
            skid_valid <= 1'b1;
        end else if (i_ready) begin
            skid_valid <= 1'b0;
        end
    end

    // Capture every word while empty, only kept if skid_valid sets
    always_ff @(posedge clk) begin
        if (o_ready) begin
            skid_data <= i_data;
            skid_resp <= i_resp;
            skid_id   <= i_id;
            skid_last <= i_last;
        end
    end

    // ------------------------------------------------------------------------
    // Output select
    // ------------------------------------------------------------------------
    // Pass through while empty, no output register
    assign o_valid = skid_valid || i_valid;
    assign o_data  = skid_valid ? skid_data : i_data;
    assign o_resp  = skid_valid ? skid_resp : i_resp;
    assign o_id    = skid_valid ? skid_id : i_id;
    assign o_last  = skid_valid ? skid_last : i_last;

endmodule

// ==== rtl/axi_rd_sub.sv ====
/* AXI read subordinate top */

`timescale 1ns/100ps

module axi_rd_sub (
    input  logic               clk,
    input  logic               rst_n,
    // AXI AR channel
    input  logic               i_arvalid,
    input  axi_rd_pkg::addr_t  i_araddr,
    input  axi_rd_pkg::len_t   i_arlen,
    input  axi_rd_pkg::size_t  i_arsize,
    input  axi_rd_pkg::burst_t i_arburst,
    input  axi_rd_pkg::id_t    i_arid,
    output logic               o_arready,
    // AXI R channel
    output logic               o_rvalid,
    output axi_rd_pkg::data_t  o_rdata,
    output axi_rd_pkg::resp_t  o_rresp,
    output axi_rd_pkg::id_t    o_rid,
    output logic               o_rlast,
    input  logic               i_rready,
    // Component port
    output logic               o_cmp_dv,
    output axi_rd_pkg::addr_t  o_cmp_addr,
    input  logic               i_cmp_hld,
    input  axi_rd_pkg::data_t  i_cmp_rdata,
    input  logic               i_cmp_err
);
    import axi_rd_pkg::*;

    // Issuer to tracker
    logic  req_fire;
    id_t   req_id;
    logic  req_last;

    // Skid chain, index g is the input of stage g
    logic  stg_valid [SKID_STAGES+1];
    data_t stg_data  [SKID_STAGES+1];
    resp_t stg_resp  [SKID_STAGES+1];
    id_t   stg_id    [SKID_STAGES+1];
    logic  stg_last  [SKID_STAGES+1];
    // Ready out of stage g, the last entry is the R channel
    // Stage 0 ready low with valid high means a lost word
    logic  stg_ready [SKID_STAGES+1];

    // ------------------------------------------------------------------------
    // Request side
    // ------------------------------------------------------------------------
    rd_burst_issuer rd_burst_issuer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_arvalid   (i_arvalid),
        .i_araddr    (i_araddr),
        .i_arlen     (i_arlen),
        .i_arsize    (i_arsize),
        .i_arburst   (i_arburst),
        .i_arid      (i_arid),
        .o_arready   (o_arready),
        .i_cmp_hld   (i_cmp_hld),
        .i_buf_ready (stg_ready[COMP_LAT]),
        .o_cmp_dv    (o_cmp_dv),
        .o_cmp_addr  (o_cmp_addr),
        .o_req_fire  (req_fire),
        .o_req_id    (req_id),
        .o_req_last  (req_last)
    );

    rd_ctx_tracker rd_ctx_tracker_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_req_fire  (req_fire),
        .i_req_id    (req_id),
        .i_req_last  (req_last),
        .o_rsp_valid (stg_valid[0]),
        .o_rsp_id    (stg_id[0]),
        .o_rsp_last  (stg_last[0])
    );

    // ------------------------------------------------------------------------
    // Response skid chain
    // ------------------------------------------------------------------------
    // Component data joins its context at stage 0
    assign stg_data[0] = i_cmp_rdata;
    assign stg_resp[0] = i_cmp_err ? RESP_SLVERR : RESP_OKAY;
    assign stg_ready[SKID_STAGES] = i_rready;

    for (genvar g = 0; g < SKID_STAGES; g++) begin : g_skid
        rd_skid_stage rd_skid_stage_i (
            .clk     (clk),
            .rst_n   (rst_n),
            .i_valid (stg_valid[g]),
            .i_data  (stg_data[g]),
            .i_resp  (stg_resp[g]),
            .i_id    (stg_id[g]),
            .i_last  (stg_last[g]),
            .o_ready (stg_ready[g]),
            .i_ready (stg_ready[g+1]),
            .o_valid (stg_valid[g+1]),
            .o_data  (stg_data[g+1]),
            .o_resp  (stg_resp[g+1]),
            .o_id    (stg_id[g+1]),
            .o_last  (stg_last[g+1])
        );
    end

    // R channel straight from the last stage
    assign o_rvalid = stg_valid[SKID_STAGES];
    assign o_rdata  = stg_data[SKID_STAGES];
    assign o_rresp  = stg_resp[SKID_STAGES];
    assign o_rid    = stg_id[SKID_STAGES];
    assign o_rlast  = stg_last[SKID_STAGES];

endmodule

// ==== tb/axi_rd_sub_checker.sv ====
/* AXI handshake assertions */

`timescale 1ns/100ps

module axi_rd_sub_checker (
    input logic               clk,
    input logic               rst_n,
    input logic               i_arvalid,
    input axi_rd_pkg::addr_t  i_araddr,
    input axi_rd_pkg::len_t   i_arlen,
    input axi_rd_pkg::size_t  i_arsize,
    input axi_rd_pkg::burst_t i_arburst,
    input axi_rd_pkg::id_t    i_arid,
    input logic               o_arready,
    input logic               o_rvalid,
    input axi_rd_pkg::data_t  o_rdata,
    input axi_rd_pkg::resp_t  o_rresp,
    input axi_rd_pkg::id_t    o_rid,
    input logic               o_rlast,
    input logic               i_rready
);
    // Master keeps the AR request until it is taken
    ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (i_arvalid && !o_arready) |=> (i_arvalid && $stable(i_araddr) && $stable(i_arlen)
            && $stable(i_arsize) && $stable(i_arburst) && $stable(i_arid)))
        else $error("AR request changed while stalled");

    // Stalled R beat holds every field
    r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (o_rvalid && !i_rready) |=> (o_rvalid && $stable(o_rdata) && $stable(o_rresp)
            && $stable(o_rid) && $stable(o_rlast)))
        else $error("R beat changed while stalled");

    // Nothing on R right after reset
    r_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !o_rvalid)
        else $error("R valid high after reset release");

endmodule

bind axi_rd_sub axi_rd_sub_checker axi_rd_sub_checker_i (.*);

// ==== tb/tb_axi_rd_sub.sv ====
/* AXI read subordinate testbench */

`timescale 1ns/100ps

module tb_axi_rd_sub;
    import axi_rd_pkg::*;

    localparam int          SEED        = 74485;
    localparam addr_t       ERR_LO      = 32'h0000_F000;
    localparam addr_t       ERR_HI      = 32'h0000_F0FF;
    localparam data_t       DATA_XOR    = 32'hA5A5_0000;
    // Odd value, never equal to the pattern of a word address
    localparam data_t       DATA_POISON = 32'hDEAD_BEEF;
    // Beats over all tests, 40 cycles of 4 ns each
    localparam int          TOTAL_BEATS = 53;
    localparam int          TIMEOUT_NS  = TOTAL_BEATS * 40 * 4;

    logic   clk;
    logic   rst_n;
    logic   i_arvalid;
    addr_t  i_araddr;
    len_t   i_arlen;
    size_t  i_arsize;
    burst_t i_arburst;
    id_t    i_arid;
    logic   o_arready;
    logic   o_rvalid;
    data_t  o_rdata;
    resp_t  o_rresp;
    id_t    o_rid;
    logic   o_rlast;
    logic   i_rready;
    logic   o_cmp_dv;
    addr_t  o_cmp_addr;
    logic   i_cmp_hld;
    data_t  i_cmp_rdata;
    logic   i_cmp_err;

    // Random R back-pressure and component hold
    logic   rand_en;
    // Component delay line, last entry drives the data
    addr_t  cmp_dly [COMP_LAT-1];
    // Accepted request flags beside the delay line
    logic   cmp_acc [COMP_LAT-1];

    // Expected beats in order
    data_t  exp_data [$];
    resp_t  exp_resp [$];
    id_t    exp_id   [$];
    logic   exp_last [$];

    axi_rd_sub axi_rd_sub_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Component model and random stall drivers
    // ------------------------------------------------------------------------
    // Only requests with dv high and hld low return real data
    always @(posedge clk) begin
        cmp_dly[0] <= o_cmp_addr;
        cmp_acc[0] <= o_cmp_dv && !i_cmp_hld;
        for (int i = 1; i < COMP_LAT - 1; i++) begin
            cmp_dly[i] <= cmp_dly[i-1];
            cmp_acc[i] <= cmp_acc[i-1];
        end
        if (cmp_acc[COMP_LAT-2]) begin
            i_cmp_rdata <= cmp_dly[COMP_LAT-2] ^ DATA_XOR;
            i_cmp_err   <= (cmp_dly[COMP_LAT-2] >= ERR_LO) && (cmp_dly[COMP_LAT-2] <= ERR_HI);
        end else begin
            i_cmp_rdata <= DATA_POISON;
            i_cmp_err   <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (rand_en) begin
            i_rready  <= ($urandom % 4) != 0;
            i_cmp_hld <= ($urandom % 4) == 0;
        end else begin
            i_rready  <= 1'b1;
            i_cmp_hld <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Checking helpers
    // ------------------------------------------------------------------------
    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Test stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            report_fail($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // Byte address of beat n from the AXI burst rules
    function automatic addr_t beat_addr(addr_t start, len_t len, size_t size,
                                        burst_t burst, int n);
        addr_t bytes;
        addr_t aligned;
        addr_t total;
        addr_t lower;
        bytes   = addr_t'(1) << size;
        aligned = (start / bytes) * bytes;
        if (burst == BURST_FIXED || n == 0) begin
            return start;
        end
        if (burst == BURST_WRAP) begin
            total = bytes * (addr_t'(len) + addr_t'(1));
            lower = (start / total) * total;
            return lower + ((aligned - lower + addr_t'(n) * bytes) % total);
        end
        return aligned + addr_t'(n) * bytes;
    endfunction

    // Queue every beat a burst should return
    task automatic expect_burst(addr_t start, len_t len, size_t size, burst_t burst, id_t id);
        addr_t w;
        for (int n = 0; n <= int'(len); n++) begin
            w = beat_addr(start, len, size, burst, n) & ~addr_t'(3);
            exp_data.push_back(w ^ DATA_XOR);
            exp_resp.push_back((w >= ERR_LO && w <= ERR_HI) ? RESP_SLVERR : RESP_OKAY);
            exp_id.push_back(id);
            exp_last.push_back(n == int'(len));
        end
    endtask

    task automatic send_ar(addr_t addr, len_t len, size_t size, burst_t burst, id_t id);
        i_arvalid <= 1'b1;
        i_araddr  <= addr;
        i_arlen   <= len;
        i_arsize  <= size;
        i_arburst <= burst;
        i_arid    <= id;
        do @(posedge clk); while (!o_arready);
        i_arvalid <= 1'b0;
    endtask

    // Wait for n R beats and compare each with the queue head
    task automatic collect_beats(int n);
        int got;
        got = 0;
        while (got < n) begin
            @(posedge clk);
            if (o_rvalid && i_rready) begin
                check_val("o_rdata", o_rdata, exp_data.pop_front());
                check_val("o_rresp", 32'(o_rresp), 32'(exp_resp.pop_front()));
                check_val("o_rid", 32'(o_rid), 32'(exp_id.pop_front()));
                check_val("o_rlast", 32'(o_rlast), 32'(exp_last.pop_front()));
                got++;
            end
        end
    endtask

    // One AR and all its beats
    task automatic run_burst(addr_t addr, len_t len, size_t size, burst_t burst, id_t id);
        expect_burst(addr, len, size, burst, id);
        fork
            send_ar(addr, len, size, burst, id);
            collect_beats(int'(len) + 1);
        join
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic test_single_beat();
        run_burst(32'h100, 8'd0, 3'd2, BURST_INCR, 4'd3);
    endtask

    task automatic test_incr_burst();
        run_burst(32'h200, 8'd7, 3'd2, BURST_INCR, 4'd1);
    endtask

    task automatic test_wrap_burst();
        run_burst(32'h1C8, 8'd3, 3'd2, BURST_WRAP, 4'd2);
    endtask

    task automatic test_fixed_and_narrow();
        run_burst(32'h300, 8'd3, 3'd2, BURST_FIXED, 4'd4);
        // Half-word beats hit each word twice
        run_burst(32'h204, 8'd3, 3'd1, BURST_INCR, 4'd6);
    endtask

    task automatic test_backpressure();
        rand_en <= 1'b1;
        run_burst(32'h400, 8'd15, 3'd2, BURST_INCR, 4'd7);
        expect_burst(32'h500, 8'd3, 3'd2, BURST_INCR, 4'd5);
        expect_burst(32'h600, 8'd3, 3'd2, BURST_INCR, 4'd9);
        fork
            begin
                send_ar(32'h500, 8'd3, 3'd2, BURST_INCR, 4'd5);
                send_ar(32'h600, 8'd3, 3'd2, BURST_INCR, 4'd9);
            end
            collect_beats(8);
        join
        rand_en <= 1'b0;
    endtask

    task automatic test_error_window();
        run_burst(32'hEFF0, 8'd7, 3'd2, BURST_INCR, 4'd8);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        logic stray_beat;
        void'($urandom(SEED));
        rst_n       = 1'b0;
        rand_en     = 1'b0;
        i_arvalid   = 1'b0;
        i_araddr    = '0;
        i_arlen     = '0;
        i_arsize    = '0;
        i_arburst   = BURST_INCR;
        i_arid      = '0;
        i_rready    = 1'b1;
        i_cmp_hld   = 1'b0;
        i_cmp_rdata = '0;
        i_cmp_err   = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        test_single_beat();
        test_incr_burst();
        test_wrap_burst();
        test_fixed_and_narrow();
        test_backpressure();
        test_error_window();

        // R stays idle once the last burst is done
        stray_beat = 1'b0;
        repeat (8) begin
            @(posedge clk);
            if (o_rvalid) begin
                stray_beat = 1'b1;
            end
        end
        if (stray_beat) begin
            report_fail("R beat arrived after the last burst");
        end else begin
            $display("RESULT: PASS");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout waiting for the DUT");
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== compile.f ====
rtl/axi_rd_pkg.sv
rtl/rd_burst_issuer.sv
rtl/rd_ctx_tracker.sv
rtl/rd_skid_stage.sv
rtl/axi_rd_sub.sv
tb/axi_rd_sub_checker.sv
tb/tb_axi_rd_sub.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_axi_rd_sub \
    -o sim_tb > sim.log 2>&1 \
    && ./obj_dir/sim_tb >> sim.log 2>&1 \
    || echo "RESULT: FAIL" >> sim.log

cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "No result found"; exit 1; }
echo "Simulation passed"
exit 0
